//--- noc_pkg.sv
package noc_pkg;

    localparam int VC_NUM = 2;                              // virtual channels on each link.
    localparam int VC_SIZE = 1;                             // bits in a vc number.

    localparam int PORT_NUM = 5;                            // output ports of a mesh router.
    localparam int PORT_SIZE = 3;                           // bits in a port code.

    localparam logic [PORT_SIZE-1:0] LOCAL = 3'd0;          // to the attached core.
    localparam logic [PORT_SIZE-1:0] NORTH = 3'd1;          // towards larger y.
    localparam logic [PORT_SIZE-1:0] SOUTH = 3'd2;          // towards smaller y.
    localparam logic [PORT_SIZE-1:0] EAST = 3'd3;           // towards larger x.
    localparam logic [PORT_SIZE-1:0] WEST = 3'd4;           // towards smaller x.

    localparam int LABEL_SIZE = 2;                          // bits in a flit label.

    localparam logic [LABEL_SIZE-1:0] HEAD = 2'd0;          // first flit, carries the route.
    localparam logic [LABEL_SIZE-1:0] BODY = 2'd1;          // middle flit, carries data.
    localparam logic [LABEL_SIZE-1:0] TAIL = 2'd2;          // last flit, releases the vc.

    localparam int COORD_SIZE = 2;                          // bits per mesh coordinate.
    localparam logic [COORD_SIZE-1:0] ROUTER_X = 2'd1;      // column of this router.
    localparam logic [COORD_SIZE-1:0] ROUTER_Y = 2'd1;      // row of this router.

    localparam int PAYLOAD_SIZE = 16;                       // bits of flit payload.
    localparam int SPARE_SIZE = PAYLOAD_SIZE - 2 * COORD_SIZE; // unused bits of a head.

    localparam int STATE_SIZE = 2;                          // bits of the per-vc state.
    localparam logic [STATE_SIZE-1:0] ST_IDLE = 2'd0;       // waiting for a head flit.
    localparam logic [STATE_SIZE-1:0] ST_VA = 2'd1;         // waiting for a downstream vc.
    localparam logic [STATE_SIZE-1:0] ST_SA = 2'd2;         // competing for the output link.

    // A head flit reads the destination, every other flit reads plain data.
    typedef union packed
    {
        struct packed
        {
            logic [COORD_SIZE-1:0] dest_x;                  // destination column.
            logic [COORD_SIZE-1:0] dest_y;                  // destination row.
            logic [SPARE_SIZE-1:0] spare;                   // free for software use.
        } head;
        logic [PAYLOAD_SIZE-1:0] data;                      // body and tail view.
    } flit_payload_u;

    // Dimension-ordered routing, x is resolved fully before y.
    function automatic logic [PORT_SIZE-1:0] xy_route(
        input logic [COORD_SIZE-1:0] dest_x,
        input logic [COORD_SIZE-1:0] dest_y
    );
        if (dest_x > ROUTER_X)
            return EAST;                                    // still left of the target.
        else if (dest_x < ROUTER_X)
            return WEST;                                    // still right of the target.
        else if (dest_y > ROUTER_Y)
            return NORTH;                                   // right column, target above.
        else if (dest_y < ROUTER_Y)
            return SOUTH;                                   // right column, target below.
        else
            return LOCAL;                                   // the packet has arrived.
    endfunction

endpackage

//--- circular_buffer.sv
`timescale 1ns/1ns

module circular_buffer
    import noc_pkg::*;
#(
    parameter int BUFFER_SIZE = 8,
    parameter int PIPELINE_DEPTH = 5
)(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  write_i,
    input  logic                  read_i,
    input  logic [LABEL_SIZE-1:0] label_i,
    input  flit_payload_u         payload_i,
    output logic [LABEL_SIZE-1:0] label_o,
    output flit_payload_u         payload_o,
    output logic                  is_full_o,
    output logic                  is_empty_o,
    output logic                  on_off_o
);

    logic [LABEL_SIZE-1:0]             label_mem [BUFFER_SIZE];   // label of each slot.
    flit_payload_u                     payload_mem [BUFFER_SIZE]; // payload of each slot.

    logic [$clog2(BUFFER_SIZE)-1:0]    wr_ptr;                    // next slot to fill.
    logic [$clog2(BUFFER_SIZE)-1:0]    rd_ptr;                    // slot of the front flit.
    logic [$clog2(BUFFER_SIZE+1)-1:0]  count;                     // flits held right now.

    logic                              do_write;                  // accepted write.
    logic                              do_read;                   // accepted read.

    assign is_full_o = (count == BUFFER_SIZE);                    // no slot left.
    assign is_empty_o = (count == 0);                             // nothing to read.

    assign do_write = write_i & ~is_full_o;                       // a write to a full fifo is dropped.
    assign do_read = read_i & ~is_empty_o;                        // a read of an empty fifo is dropped.

    // Upstream needs PIPELINE_DEPTH free slots to absorb the flits already on the link.
    assign on_off_o = (BUFFER_SIZE - int'(count)) >= PIPELINE_DEPTH;

    assign label_o = label_mem[rd_ptr];                           // front flit is always visible.
    assign payload_o = payload_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            label_mem[wr_ptr] <= label_i;
            payload_mem[wr_ptr] <= payload_i;
        end
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_write)
            begin
                if (wr_ptr == BUFFER_SIZE - 1)
                    wr_ptr <= '0;                                 // wrap to the first slot.
                else
                    wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                if (rd_ptr == BUFFER_SIZE - 1)
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;                   // only a write.
                2'b01:   count <= count - 1'b1;                   // only a read.
                default: count <= count;                          // both or neither.
            endcase
        end
    end

endmodule

//--- input_buffer.sv
`timescale 1ns/1ns

module input_buffer
    import noc_pkg::*;
#(
    parameter int BUFFER_SIZE = 8,
    parameter int PIPELINE_DEPTH = 5
)(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  write_i,
    input  logic [LABEL_SIZE-1:0] label_i,
    input  flit_payload_u         payload_i,
    input  logic                  read_i,
    input  logic                  vc_valid_i,
    input  logic [VC_SIZE-1:0]    vc_new_i,
    output logic                  va_req_o,
    output logic                  sa_ready_o,
    output logic                  tail_read_o,
    output logic [PORT_SIZE-1:0]  out_port_o,
    output logic [LABEL_SIZE-1:0] label_o,
    output flit_payload_u         payload_o,
    output logic [VC_SIZE-1:0]    vc_id_o,
    output logic                  on_off_o
);

    logic [STATE_SIZE-1:0] state;                 // current packet phase.
    logic [STATE_SIZE-1:0] state_next;
    logic [PORT_SIZE-1:0]  route_next;            // output port of the next packet.
    logic [VC_SIZE-1:0]    downstream_vc;         // vc granted on the next router.
    logic [VC_SIZE-1:0]    downstream_vc_next;
    logic                  read_cmd;              // read that reaches the fifo.
    logic                  is_full;
    logic                  is_empty;

    circular_buffer #(
        .BUFFER_SIZE    (BUFFER_SIZE),
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) u_circular_buffer (
        .clk        (clk),
        .rst        (rst),
        .write_i    (write_i),
        .read_i     (read_cmd),
        .label_i    (label_i),
        .payload_i  (payload_i),
        .label_o    (label_o),
        .payload_o  (payload_o),
        .is_full_o  (is_full),
        .is_empty_o (is_empty),
        .on_off_o   (on_off_o)
    );

    assign read_cmd = read_i & (state == ST_SA);                      // reads only count in sa.
    assign va_req_o = (state == ST_VA);                               // ask for a downstream vc.
    assign sa_ready_o = (state == ST_SA) & ~is_empty;                 // a flit is waiting to go.
    assign tail_read_o = read_cmd & ~is_empty & (label_o == TAIL);    // packet leaves the buffer.
    assign vc_id_o = downstream_vc;

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
            out_port_o <= LOCAL;
            downstream_vc <= '0;
        end
        else
        begin
            state <= state_next;
            out_port_o <= route_next;
            downstream_vc <= downstream_vc_next;
        end
    end

    always_comb
    begin
        state_next = state;
        route_next = out_port_o;
        downstream_vc_next = downstream_vc;
        case (state)
            ST_IDLE:
            begin
                // a head that queued up behind the last tail is routed from the front.
                if (!is_empty && label_o == HEAD)
                begin
                    state_next = ST_VA;
                    route_next = xy_route(payload_o.head.dest_x, payload_o.head.dest_y);
                end
                else if (write_i && is_empty && label_i == HEAD)
                begin
                    state_next = ST_VA;                               // route straight from the link.
                    route_next = xy_route(payload_i.head.dest_x, payload_i.head.dest_y);
                end
            end
            ST_VA:
            begin
                if (vc_valid_i)
                begin
                    state_next = ST_SA;
                    downstream_vc_next = vc_new_i;                    // keep it for every flit.
                end
            end
            ST_SA:
            begin
                if (tail_read_o)
                    state_next = ST_IDLE;                             // packet is gone.
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

endmodule

//--- vc_allocator.sv
`timescale 1ns/1ns

module vc_allocator
    import noc_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic [VC_NUM-1:0]                   va_req_i,
    input  logic [VC_NUM-1:0][PORT_SIZE-1:0]    req_port_i,
    input  logic [VC_NUM-1:0]                   tail_read_i,
    output logic [VC_NUM-1:0]                   vc_valid_o,
    output logic [VC_NUM-1:0][VC_SIZE-1:0]      vc_new_o
);

    logic [PORT_NUM-1:0][VC_NUM-1:0]  busy;       // downstream vc in use, per output port.
    logic [VC_NUM-1:0][PORT_SIZE-1:0] held_port;  // port held by each input vc.
    logic [VC_NUM-1:0][VC_SIZE-1:0]   held_vc;    // downstream vc held by each input vc.
    logic [PORT_NUM-1:0]              port_taken; // port already granted this cycle.
    logic                             found;      // a free vc was seen on the port.

    // Input vcs are served in index order, so the lowest requester wins a port.
    always_comb
    begin
        vc_valid_o = '0;
        vc_new_o = '0;
        port_taken = '0;
        found = 1'b0;
        for (int i = 0; i < VC_NUM; i++)
        begin
            found = 1'b0;
            if (va_req_i[i] && !port_taken[req_port_i[i]])
            begin
                for (int v = VC_NUM - 1; v >= 0; v--)
                begin
                    if (!busy[req_port_i[i]][v])
                    begin
                        found = 1'b1;                     // the last hit is the lowest free vc.
                        vc_new_o[i] = VC_SIZE'(v);
                    end
                end
                vc_valid_o[i] = found;
                port_taken[req_port_i[i]] = found;        // one grant per port per cycle.
            end
        end
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            busy <= '0;
            held_port <= '0;
            held_vc <= '0;
        end
        else
        begin
            for (int i = 0; i < VC_NUM; i++)
            begin
                if (tail_read_i[i])
                    busy[held_port[i]][held_vc[i]] <= 1'b0;   // tail left, vc is free again.
            end
            for (int i = 0; i < VC_NUM; i++)
            begin
                if (vc_valid_o[i])
                begin
                    busy[req_port_i[i]][vc_new_o[i]] <= 1'b1;
                    held_port[i] <= req_port_i[i];            // remembered for the release.
                    held_vc[i] <= vc_new_o[i];
                end
            end
        end
    end

endmodule

//--- switch_arbiter.sv
`timescale 1ns/1ns

module switch_arbiter
    import noc_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [VC_NUM-1:0] ready_i,
    output logic [VC_NUM-1:0] read_o
);

    logic [VC_SIZE-1:0] last_q;     // vc that won most recently.
    logic [VC_SIZE-1:0] cand;       // vc looked at in the search.
    logic [VC_SIZE-1:0] winner;     // vc granted this cycle.
    logic               granted;    // some vc was ready.

    // The search starts just after the last winner and wraps round once.
    always_comb
    begin
        read_o = '0;
        granted = 1'b0;
        winner = last_q;
        cand = last_q;
        for (int k = 1; k <= VC_NUM; k++)
        begin
            cand = VC_SIZE'((int'(last_q) + k) % VC_NUM);
            if (!granted && ready_i[cand])
            begin
                granted = 1'b1;     // first ready vc in rotation order.
                winner = cand;
            end
        end
        read_o[winner] = granted;   // one-hot, or all zero when nobody is ready.
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            last_q <= VC_SIZE'(VC_NUM - 1); // so vc 0 is first after reset.
        end
        else if (granted)
        begin
            last_q <= winner;
        end
    end

endmodule

//--- router_input_unit.sv
`timescale 1ns/1ns

module router_input_unit
    import noc_pkg::*;
#(
    parameter int BUFFER_SIZE = 8,
    parameter int PIPELINE_DEPTH = 5
)(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flit_valid_i,
    input  logic [LABEL_SIZE-1:0] flit_label_i,
    input  logic [VC_SIZE-1:0]    flit_vc_i,
    input  flit_payload_u         flit_payload_i,
    output logic [VC_NUM-1:0]     on_off_o,
    output logic                  out_valid_o,
    output logic [LABEL_SIZE-1:0] out_label_o,
    output logic [VC_SIZE-1:0]    out_vc_o,
    output logic [PORT_SIZE-1:0]  out_port_o,
    output flit_payload_u         out_payload_o
);

    logic [VC_NUM-1:0]                 write_vc;     // write strobe per input vc.
    logic [VC_NUM-1:0]                 va_req;
    logic [VC_NUM-1:0]                 sa_ready;
    logic [VC_NUM-1:0]                 tail_read;
    logic [VC_NUM-1:0]                 vc_valid;
    logic [VC_NUM-1:0]                 read;         // one-hot read from the arbiter.
    logic [VC_NUM-1:0][VC_SIZE-1:0]    vc_new;
    logic [VC_NUM-1:0][PORT_SIZE-1:0]  req_port;
    logic [VC_NUM-1:0][LABEL_SIZE-1:0] buf_label;
    logic [VC_NUM-1:0][VC_SIZE-1:0]    buf_vc_id;
    flit_payload_u                     buf_payload [VC_NUM];
    logic [VC_SIZE-1:0]                sel;          // buffer chosen for the link.

    for (genvar v = 0; v < VC_NUM; v++)
    begin : gen_vc
        assign write_vc[v] = flit_valid_i & (flit_vc_i == VC_SIZE'(v)); // route the write by vc.

        input_buffer #(
            .BUFFER_SIZE    (BUFFER_SIZE),
            .PIPELINE_DEPTH (PIPELINE_DEPTH)
        ) u_input_buffer (
            .clk         (clk),
            .rst         (rst),
            .write_i     (write_vc[v]),
            .label_i     (flit_label_i),
            .payload_i   (flit_payload_i),
            .read_i      (read[v]),
            .vc_valid_i  (vc_valid[v]),
            .vc_new_i    (vc_new[v]),
            .va_req_o    (va_req[v]),
            .sa_ready_o  (sa_ready[v]),
            .tail_read_o (tail_read[v]),
            .out_port_o  (req_port[v]),
            .label_o     (buf_label[v]),
            .payload_o   (buf_payload[v]),
            .vc_id_o     (buf_vc_id[v]),
            .on_off_o    (on_off_o[v])
        );
    end

    vc_allocator u_vc_allocator (
        .clk         (clk),
        .rst         (rst),
        .va_req_i    (va_req),
        .req_port_i  (req_port),
        .tail_read_i (tail_read),
        .vc_valid_o  (vc_valid),
        .vc_new_o    (vc_new)
    );

    switch_arbiter u_switch_arbiter (
        .clk     (clk),
        .rst     (rst),
        .ready_i (sa_ready),
        .read_o  (read)
    );

    always_comb
    begin
        sel = '0;
        for (int v = 0; v < VC_NUM; v++)
        begin
            if (read[v])
                sel = VC_SIZE'(v);        // read is one-hot, so one index matches.
        end
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
            out_valid_o <= 1'b0;
        else
            out_valid_o <= |read;         // one flit per read cycle.
    end

    // The flit fields are loaded from the buffer that was read.
    always_ff @(posedge clk)
    begin
        if (|read)
        begin
            out_label_o <= buf_label[sel];
            out_vc_o <= buf_vc_id[sel];
            out_port_o <= req_port[sel];
            out_payload_o <= buf_payload[sel];
        end
    end

endmodule

//--- router_input_unit_checker.sv
`timescale 1ns/1ns

module router_input_unit_checker
    import noc_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic [VC_NUM-1:0]  write_vc_i,
    input logic [VC_NUM-1:0]  full_i,
    input logic [VC_NUM-1:0]  read_i,
    input logic               out_valid_i
);

    no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        (write_vc_i & full_i) == '0)
        else $error("flit written into a full vc buffer.");

    valid_follows_read: assert property (@(posedge clk) disable iff (rst)
        out_valid_i |-> $past(|read_i))
        else $error("output strobe without a read in the cycle before.");

    quiet_in_reset: assert property (@(negedge clk) rst |-> !out_valid_i)
        else $error("output strobe while reset is asserted.");

endmodule

bind router_input_unit router_input_unit_checker i_checker (
    .clk         (clk),
    .rst         (rst),
    .write_vc_i  (write_vc),
    .full_i      ({gen_vc[1].u_input_buffer.is_full, gen_vc[0].u_input_buffer.is_full}),
    .read_i      (read),
    .out_valid_i (out_valid_o)
);

//--- router_input_unit_tb.sv
`timescale 1ns/1ns

module router_input_unit_tb
    import noc_pkg::*;
();

    localparam int NPKT = 12;                              // packets in the table.
    localparam int MAX_LEN = 6;                            // longest packet in flits.
    localparam int C_VC = 0;
    localparam int C_DX = 1;
    localparam int C_DY = 2;
    localparam int C_LEN = 3;
    localparam int C_GAP = 4;
    localparam int C_PORT = 5;
    localparam int C_DVC = 6;

    // columns: input vc, dest_x, dest_y, length, start gap, expected port, downstream vc.
    localparam int PKT_TABLE [NPKT][7] = '{
        '{0, 2, 1, 3,  4, EAST,  0},                       // one packet per xy class on vc 0.
        '{0, 0, 2, 4, 10, WEST,  0},
        '{0, 1, 3, 2, 10, NORTH, 0},
        '{0, 1, 0, 5, 10, SOUTH, 0},
        '{0, 1, 1, 6, 10, LOCAL, 0},
        '{0, 3, 0, 5, 10, EAST,  0},                       // next row shares the link with this one.
        '{1, 1, 2, 4,  0, NORTH, 0},
        '{0, 0, 0, 4, 10, WEST,  0},                       // both vcs head west at once.
        '{1, 0, 3, 6,  0, WEST,  1},                       // second grant finds vc 0 taken.
        '{1, 1, 2, 3, 10, NORTH, 0},                       // back to back on vc 1.
        '{1, 1, 3, 2,  0, NORTH, 0},                       // reuses the vc freed by the tail.
        '{1, 1, 2, 4,  0, NORTH, 0}
    };

    logic                  clk;
    logic                  rst;
    logic                  flit_valid_i;
    logic [LABEL_SIZE-1:0] flit_label_i;
    logic [VC_SIZE-1:0]    flit_vc_i;
    flit_payload_u         flit_payload_i;
    logic [VC_NUM-1:0]     on_off_o;
    logic                  out_valid_o;
    logic [LABEL_SIZE-1:0] out_label_o;
    logic [VC_SIZE-1:0]    out_vc_o;
    logic [PORT_SIZE-1:0]  out_port_o;
    flit_payload_u         out_payload_o;

    logic [LABEL_SIZE-1:0]   exp_label [NPKT][MAX_LEN];    // expected labels per packet.
    logic [PAYLOAD_SIZE-1:0] exp_payload [NPKT][MAX_LEN];  // expected payload words.
    int                      open_pkt [2**PORT_SIZE][VC_NUM]; // packet owning each port and vc.
    int                      next_pos [NPKT];              // next flit due from each packet.
    int                      out_count;                    // flits seen at the output.
    int                      total_flits;
    int                      timeout_limit;
    int                      cycle_count;
    logic [31:0]             lcg_state;

    router_input_unit i_dut (
        .clk            (clk),
        .rst            (rst),
        .flit_valid_i   (flit_valid_i),
        .flit_label_i   (flit_label_i),
        .flit_vc_i      (flit_vc_i),
        .flit_payload_i (flit_payload_i),
        .on_off_o       (on_off_o),
        .out_valid_o    (out_valid_o),
        .out_label_o    (out_label_o),
        .out_vc_o       (out_vc_o),
        .out_port_o     (out_port_o),
        .out_payload_o  (out_payload_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                             // 8 ns period.
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];                           // upper bits have the longer period.
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual)
        else abort_run($sformatf("Fail %s: expected %0h, actual %0h", name, expected, actual));
    endtask

    task automatic build_expected();
        flit_payload_u head_word;
        int            len;
        lcg_state = 32'hb93d953f;
        total_flits = 0;
        for (int p = 0; p < NPKT; p++)
        begin
            len = PKT_TABLE[p][C_LEN];
            head_word.head.dest_x = COORD_SIZE'(PKT_TABLE[p][C_DX]);
            head_word.head.dest_y = COORD_SIZE'(PKT_TABLE[p][C_DY]);
            head_word.head.spare = SPARE_SIZE'(p);         // packet number tags the head.
            exp_label[p][0] = HEAD;
            exp_payload[p][0] = head_word.data;
            for (int k = 1; k < len; k++)
            begin
                exp_label[p][k] = (k == len - 1) ? TAIL : BODY;
                exp_payload[p][k] = lcg_next();
            end
            next_pos[p] = 0;
            total_flits += len;
        end
        foreach (open_pkt[i, j])
            open_pkt[i][j] = -1;                           // no packet holds any vc yet.
        timeout_limit = 40 + 8 * total_flits;
    endtask

    // One flit per call, held back while the target vc is throttled.
    task automatic send_flit(input int pkt, input int pos);
        @(negedge clk);
        while (!on_off_o[PKT_TABLE[pkt][C_VC]])
        begin
            @(posedge clk);
            flit_valid_i <= 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        flit_valid_i <= 1'b1;
        flit_label_i <= exp_label[pkt][pos];
        flit_vc_i <= VC_SIZE'(PKT_TABLE[pkt][C_VC]);
        flit_payload_i <= exp_payload[pkt][pos];
    endtask

    task automatic idle_link(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            flit_valid_i <= 1'b0;
        end
    endtask

    // A zero gap on the other vc makes the two packets alternate flit by flit.
    task automatic send_table();
        int i;
        i = 0;
        while (i < NPKT)
        begin
            idle_link(PKT_TABLE[i][C_GAP]);
            if (i + 1 < NPKT && PKT_TABLE[i + 1][C_GAP] == 0 &&
                PKT_TABLE[i + 1][C_VC] != PKT_TABLE[i][C_VC])
            begin
                for (int k = 0; k < MAX_LEN; k++)
                begin
                    if (k < PKT_TABLE[i][C_LEN])
                        send_flit(i, k);
                    if (k < PKT_TABLE[i + 1][C_LEN])
                        send_flit(i + 1, k);
                end
                i += 2;
            end
            else
            begin
                for (int k = 0; k < PKT_TABLE[i][C_LEN]; k++)
                    send_flit(i, k);
                i += 1;
            end
        end
        idle_link(1);
    endtask

    // Heads open a port and vc pair, later flits on that pair must follow in order.
    task automatic check_output();
        int    pkt;
        int    pos;
        string tag;
        if (out_label_o == HEAD)
        begin
            pkt = int'(out_payload_o.head.spare);
            assert (pkt < NPKT && next_pos[pkt] == 0)
            else abort_run($sformatf("head of unknown or repeated packet %0d came out.", pkt));
            assert (open_pkt[out_port_o][out_vc_o] < 0)
            else abort_run($sformatf("port %0d vc %0d got a head before the last tail.",
                                     out_port_o, out_vc_o));
            check_equal($sformatf("pkt%0d port", pkt), PKT_TABLE[pkt][C_PORT], out_port_o);
            check_equal($sformatf("pkt%0d vc", pkt), PKT_TABLE[pkt][C_DVC], out_vc_o);
            open_pkt[out_port_o][out_vc_o] = pkt;
        end
        else
        begin
            pkt = open_pkt[out_port_o][out_vc_o];
            assert (pkt >= 0)
            else abort_run($sformatf("flit on port %0d vc %0d belongs to no open packet.",
                                     out_port_o, out_vc_o));
        end
        pos = next_pos[pkt];
        tag = $sformatf("pkt%0d flit%0d", pkt, pos);
        check_equal({tag, " label"}, exp_label[pkt][pos], out_label_o);
        check_equal({tag, " payload"}, exp_payload[pkt][pos], out_payload_o.data);
        next_pos[pkt] = pos + 1;
        if (out_label_o == TAIL)
            open_pkt[out_port_o][out_vc_o] = -1;           // downstream vc closed.
        out_count++;
    endtask

    always @(negedge clk)
    begin
        if (!rst && out_valid_o)
            check_output();                                // outputs settled half a cycle ago.
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit)
            abort_run($sformatf("timeout: only %0d of %0d flits came out in %0d cycles.",
                                out_count, total_flits, timeout_limit));
    end

    initial
    begin
        rst = 1'b1;
        flit_valid_i = 1'b0;
        flit_label_i = HEAD;
        flit_vc_i = '0;
        flit_payload_i = '0;
        out_count = 0;
        cycle_count = 0;
        build_expected();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4)
        begin
            @(negedge clk);
            assert (!out_valid_o && on_off_o == {VC_NUM{1'b1}})
            else abort_run("output strobe or upstream throttling seen before the first write.");
        end
        send_table();
        while (out_count < total_flits)
            @(posedge clk);
        repeat (10) @(posedge clk);                        // room for any stray extra flit.
        if (out_count == total_flits)
        begin
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            abort_run($sformatf("Fail flit count: expected %0d, actual %0d",
                                total_flits, out_count));
        end
    end

endmodule

//--- router_input_unit.f
noc_pkg.sv
circular_buffer.sv
input_buffer.sv
vc_allocator.sv
switch_arbiter.sv
router_input_unit.sv
router_input_unit_checker.sv
router_input_unit_tb.sv

//--- Bender.yml
package:
  name: router_input_unit

sources:
  - noc_pkg.sv
  - circular_buffer.sv
  - input_buffer.sv
  - vc_allocator.sv
  - switch_arbiter.sv
  - router_input_unit.sv
  - target: test
    files:
      - router_input_unit_checker.sv
      - router_input_unit_tb.sv
